//--- src/core_pkg.sv
package core_pkg;

  //////////////////////////////
  // Widths and encodings
  //////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // Major opcodes, RV32I base
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 values shared by register and immediate forms
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct7, SUB is the only alternate form supported
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  //////////////////////////////
  // Instruction views
  //////////////////////////////

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  // Same 32-bit word, read as R-type or I-type
  typedef union packed {
    r_type_t rtype;
    i_type_t itype;
  } instr_u;

  //////////////////////////////
  // Pipe registers
  //////////////////////////////

  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] rd;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    logic                  we;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       result;
  } ex_wb_t;

  // Result in flight, seen by decode
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } fwd_t;

endpackage

//--- src/decode_stage.sv
module decode_stage (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            instr_valid_i,
  input  core_pkg::instr_u                instr_i,
  output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [core_pkg::XLEN-1:0]       rs1_rdata_i,
  input  logic [core_pkg::XLEN-1:0]       rs2_rdata_i,
  input  core_pkg::fwd_t                  ex_fwd_i,
  input  core_pkg::fwd_t                  wb_fwd_i,
  output core_pkg::id_ex_t                id_ex_o
);
  import core_pkg::*;

  id_ex_t          id_ex_d;
  id_ex_t          id_ex_q;
  alu_op_e         alu_op;
  logic            legal;
  logic            use_imm;
  logic [XLEN-1:0] imm_sext;
  logic [XLEN-1:0] rs1_value;
  logic [XLEN-1:0] rs2_value;

  // Newest value wins: execute, then write-back, then register file
  function automatic logic [XLEN-1:0] pick_operand(
    input logic [REG_ADDR_W-1:0] addr,
    input logic [XLEN-1:0]       rf_data,
    input fwd_t                  ex_fwd,
    input fwd_t                  wb_fwd
  );
    logic [XLEN-1:0] value;
    value = rf_data;
    if (ex_fwd.we && (ex_fwd.rd == addr) && (addr != '0)) begin
      value = ex_fwd.data;
    end else if (wb_fwd.we && (wb_fwd.rd == addr) && (addr != '0)) begin
      value = wb_fwd.data;
    end
    return value;
  endfunction

  //////////////////////////////
  // Instruction decode
  //////////////////////////////

  always_comb begin
    alu_op  = ALU_ADD;
    legal   = 1'b0;
    use_imm = 1'b0;
    case (instr_i.rtype.opcode)
      OPC_OP: begin
        // SUB only pairs with the ADD funct3
        legal = (instr_i.rtype.funct7 == F7_BASE);
        case (instr_i.rtype.funct3)
          F3_ADD: begin
            if (instr_i.rtype.funct7 == F7_SUB) begin
              alu_op = ALU_SUB;
              legal  = 1'b1;
            end
          end
          F3_SLT:  alu_op = ALU_SLT;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: legal  = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        legal   = 1'b1;
        case (instr_i.itype.funct3)
          F3_ADD:  alu_op = ALU_ADD;
          F3_SLT:  alu_op = ALU_SLT;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: legal  = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  // 12-bit immediate, sign extended
  assign imm_sext = {{(XLEN-12){instr_i.itype.imm12[11]}}, instr_i.itype.imm12};

  // rs1 sits at the same bits in both views
  assign rs1_addr_o = instr_i.rtype.rs1;
  assign rs2_addr_o = instr_i.rtype.rs2;

  assign rs1_value = pick_operand(rs1_addr_o, rs1_rdata_i, ex_fwd_i, wb_fwd_i);
  assign rs2_value = pick_operand(rs2_addr_o, rs2_rdata_i, ex_fwd_i, wb_fwd_i);

  always_comb begin
    id_ex_d.valid     = instr_valid_i;
    id_ex_d.illegal   = instr_valid_i & ~legal;
    id_ex_d.alu_op    = alu_op;
    id_ex_d.operand_a = rs1_value;
    id_ex_d.operand_b = use_imm ? imm_sext : rs2_value;
    id_ex_d.rd        = instr_i.rtype.rd;
  end

  //////////////////////////////
  // Decode to execute register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_ex_q.valid   <= 1'b0;
      id_ex_q.illegal <= 1'b0;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

//--- src/execute_stage.sv
module execute_stage (
  input  logic             clk_i,
  input  logic             reset_i,
  input  core_pkg::id_ex_t id_ex_i,
  output core_pkg::fwd_t   ex_fwd_o,
  output core_pkg::ex_wb_t ex_wb_o
);
  import core_pkg::*;

  logic [XLEN-1:0] alu_result;
  logic            less_than;
  ex_wb_t          ex_wb_d;
  ex_wb_t          ex_wb_q;

  //////////////////////////////
  // ALU
  //////////////////////////////

  // Signed compare for SLT and SLTI
  assign less_than = $signed(id_ex_i.operand_a) < $signed(id_ex_i.operand_b);

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD: alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
      ALU_SUB: alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      ALU_AND: alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      ALU_OR:  alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      ALU_XOR: alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, less_than};
      default: alu_result = '0;
    endcase
  end

  // Item in execute, offered to decode
  // No write for bubbles, illegal encodings or x0
  assign ex_fwd_o.we   = id_ex_i.valid & ~id_ex_i.illegal & (id_ex_i.rd != '0);
  assign ex_fwd_o.rd   = id_ex_i.rd;
  assign ex_fwd_o.data = alu_result;

  always_comb begin
    ex_wb_d.valid   = id_ex_i.valid;
    ex_wb_d.illegal = id_ex_i.valid & id_ex_i.illegal;
    ex_wb_d.we      = ex_fwd_o.we;
    ex_wb_d.rd      = id_ex_i.rd;
    ex_wb_d.result  = alu_result;
  end

  //////////////////////////////
  // Execute to write-back register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_wb_q.valid   <= 1'b0;
      ex_wb_q.illegal <= 1'b0;
      ex_wb_q.we      <= 1'b0;
    end else begin
      ex_wb_q <= ex_wb_d;
    end
  end

  assign ex_wb_o = ex_wb_q;

endmodule

//--- src/result_stage.sv
module result_stage (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  core_pkg::ex_wb_t                ex_wb_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic [core_pkg::XLEN-1:0]       rs1_rdata_o,
  output logic [core_pkg::XLEN-1:0]       rs2_rdata_o,
  output core_pkg::fwd_t                  wb_fwd_o,
  output logic                            wb_valid_o,
  output logic                            wb_we_o,
  output logic                            illegal_o,
  output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [core_pkg::XLEN-1:0]       wb_data_o
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  //////////////////////////////
  // Register file
  //////////////////////////////

  // Cleared on reset, one write port
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int idx = 0; idx < NUM_REGS; idx++) begin
        regs[idx] <= '0;
      end
    end else if (ex_wb_i.we && (ex_wb_i.rd != '0)) begin
      regs[ex_wb_i.rd] <= ex_wb_i.result;
    end
  end

  // Asynchronous reads
  // x0 reads zero regardless of storage
  assign rs1_rdata_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_rdata_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  //////////////////////////////
  // Write-back outputs
  //////////////////////////////

  // Forward of the write still on its way into the file
  assign wb_fwd_o.we   = ex_wb_i.we;
  assign wb_fwd_o.rd   = ex_wb_i.rd;
  assign wb_fwd_o.data = ex_wb_i.result;

  // Straight from the pipe register, one cycle per item
  assign wb_valid_o = ex_wb_i.valid;
  assign wb_we_o    = ex_wb_i.we;
  assign illegal_o  = ex_wb_i.illegal;
  assign wb_rd_o    = ex_wb_i.rd;
  assign wb_data_o  = ex_wb_i.result;

endmodule

//--- src/tiny_core.sv
module tiny_core (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            instr_valid_i,
  input  core_pkg::instr_u                instr_i,
  output logic                            wb_valid_o,
  output logic                            wb_we_o,
  output logic                            illegal_o,
  output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [core_pkg::XLEN-1:0]       wb_data_o
);
  import core_pkg::*;

  // Pipe registers between stages
  id_ex_t id_ex;
  ex_wb_t ex_wb;

  // Forwards back into decode
  fwd_t ex_fwd;
  fwd_t wb_fwd;

  // Register file read ports
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_rdata;
  logic [XLEN-1:0]       rs2_rdata;

  //////////////////////////////
  // Decode
  //////////////////////////////

  decode_stage u_decode_stage (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_rdata_i   (rs1_rdata),
    .rs2_rdata_i   (rs2_rdata),
    .ex_fwd_i      (ex_fwd),
    .wb_fwd_i      (wb_fwd),
    .id_ex_o       (id_ex)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////

  execute_stage u_execute_stage (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .id_ex_i  (id_ex),
    .ex_fwd_o (ex_fwd),
    .ex_wb_o  (ex_wb)
  );

  //////////////////////////////
  // Write-back and register file
  //////////////////////////////

  result_stage u_result_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ex_wb_i     (ex_wb),
    .rs1_addr_i  (rs1_addr),
    .rs2_addr_i  (rs2_addr),
    .rs1_rdata_o (rs1_rdata),
    .rs2_rdata_o (rs2_rdata),
    .wb_fwd_o    (wb_fwd),
    .wb_valid_o  (wb_valid_o),
    .wb_we_o     (wb_we_o),
    .illegal_o   (illegal_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o)
  );

endmodule

//--- test/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: instruction, expected we, expected illegal, expected rd, expected data
// Entries run in program order, so every value follows from the ones above it

task automatic load_vectors();
  // Idle pipe, then a read of two registers never written
  push_bubble();
  push_bubble();
  push_vector(enc_r(F7_BASE, F3_ADD, 5'd1, 5'd2, 5'd3), 1'b1, 1'b0, 5'd1, 32'h0000_0000);

  //////////////////////////////
  // Immediate forms
  push_vector(enc_i(F3_ADD, 5'd2, 5'd0, 12'h123), 1'b1, 1'b0, 5'd2, 32'h0000_0123);
  push_vector(enc_i(F3_ADD, 5'd3, 5'd0, 12'hfff), 1'b1, 1'b0, 5'd3, 32'hffff_ffff);
  push_vector(enc_i(F3_ADD, 5'd4, 5'd0, 12'h800), 1'b1, 1'b0, 5'd4, 32'hffff_f800);
  push_vector(enc_i(F3_AND, 5'd5, 5'd3, 12'h0f0), 1'b1, 1'b0, 5'd5, 32'h0000_00f0);
  push_vector(enc_i(F3_OR, 5'd6, 5'd2, 12'h800), 1'b1, 1'b0, 5'd6, 32'hffff_f923);
  push_vector(enc_i(F3_XOR, 5'd7, 5'd2, 12'hfff), 1'b1, 1'b0, 5'd7, 32'hffff_fedc);
  // Negative register against positive immediate, and the reverse
  push_vector(enc_i(F3_SLT, 5'd8, 5'd4, 12'h001), 1'b1, 1'b0, 5'd8, 32'h0000_0001);
  push_vector(enc_i(F3_SLT, 5'd9, 5'd2, 12'h800), 1'b1, 1'b0, 5'd9, 32'h0000_0000);

  //////////////////////////////
  // Register forms
  push_vector(enc_r(F7_BASE, F3_ADD, 5'd10, 5'd2, 5'd4), 1'b1, 1'b0, 5'd10, 32'hffff_f923);
  push_vector(enc_r(F7_SUB, F3_ADD, 5'd11, 5'd2, 5'd4), 1'b1, 1'b0, 5'd11, 32'h0000_0923);
  push_vector(enc_r(F7_BASE, F3_AND, 5'd12, 5'd6, 5'd7), 1'b1, 1'b0, 5'd12, 32'hffff_f800);
  push_vector(enc_r(F7_BASE, F3_OR, 5'd13, 5'd2, 5'd5), 1'b1, 1'b0, 5'd13, 32'h0000_01f3);
  push_vector(enc_r(F7_BASE, F3_XOR, 5'd14, 5'd6, 5'd10), 1'b1, 1'b0, 5'd14, 32'h0000_0000);
  push_vector(enc_r(F7_BASE, F3_SLT, 5'd15, 5'd4, 5'd2), 1'b1, 1'b0, 5'd15, 32'h0000_0001);
  push_vector(enc_r(F7_BASE, F3_SLT, 5'd16, 5'd2, 5'd3), 1'b1, 1'b0, 5'd16, 32'h0000_0000);

  //////////////////////////////
  // Dependent chains at distance 1, 2 and 3
  push_vector(enc_i(F3_ADD, 5'd17, 5'd0, 12'h010), 1'b1, 1'b0, 5'd17, 32'h0000_0010);
  push_vector(enc_r(F7_BASE, F3_ADD, 5'd18, 5'd17, 5'd17), 1'b1, 1'b0, 5'd18, 32'h0000_0020);
  push_vector(enc_r(F7_BASE, F3_ADD, 5'd19, 5'd18, 5'd17), 1'b1, 1'b0, 5'd19, 32'h0000_0030);
  push_vector(enc_r(F7_SUB, F3_ADD, 5'd20, 5'd19, 5'd17), 1'b1, 1'b0, 5'd20, 32'h0000_0020);
  push_vector(enc_r(F7_BASE, F3_XOR, 5'd21, 5'd20, 5'd19), 1'b1, 1'b0, 5'd21, 32'h0000_0010);
  // Same target rewritten, newest value has to win
  push_vector(enc_i(F3_ADD, 5'd22, 5'd0, 12'h001), 1'b1, 1'b0, 5'd22, 32'h0000_0001);
  push_vector(enc_i(F3_ADD, 5'd22, 5'd22, 12'h001), 1'b1, 1'b0, 5'd22, 32'h0000_0002);
  push_vector(enc_i(F3_ADD, 5'd22, 5'd22, 12'h001), 1'b1, 1'b0, 5'd22, 32'h0000_0003);
  push_vector(enc_i(F3_ADD, 5'd22, 5'd22, 12'h001), 1'b1, 1'b0, 5'd22, 32'h0000_0004);

  //////////////////////////////
  // x0 as a target
  push_vector(enc_i(F3_ADD, 5'd0, 5'd0, 12'h555), 1'b0, 1'b0, 5'd0, 32'h0000_0000);
  push_vector(enc_r(F7_BASE, F3_ADD, 5'd23, 5'd0, 5'd0), 1'b1, 1'b0, 5'd23, 32'h0000_0000);
  push_vector(enc_i(F3_ADD, 5'd24, 5'd0, 12'h7ff), 1'b1, 1'b0, 5'd24, 32'h0000_07ff);

  //////////////////////////////
  // Illegal encodings aimed at x24
  push_vector(32'h0000_2c03, 1'b0, 1'b1, 5'd24, 32'h0000_0000);
  push_vector(enc_r(7'b0000001, F3_ADD, 5'd24, 5'd2, 5'd3), 1'b0, 1'b1, 5'd24, 32'h0000_0000);
  push_vector(enc_r(F7_SUB, F3_XOR, 5'd24, 5'd2, 5'd3), 1'b0, 1'b1, 5'd24, 32'h0000_0000);
  // x24 still holds its old value, x0 still reads zero
  push_vector(enc_i(F3_ADD, 5'd25, 5'd24, 12'h000), 1'b1, 1'b0, 5'd25, 32'h0000_07ff);
  push_vector(enc_r(F7_BASE, F3_ADD, 5'd26, 5'd0, 5'd0), 1'b1, 1'b0, 5'd26, 32'h0000_0000);
  push_bubble();
  push_bubble();
endtask

`endif

//--- test/tb_tiny_core.sv
module tb_tiny_core;
  import core_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_RANDOM = 200;

  // One issued slot and what write-back should show for it
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic        we;
    logic        illegal;
    logic [4:0]  rd;
    logic [31:0] data;
  } vector_t;

  logic        clk_i;
  logic        reset_i;
  logic        instr_valid_i;
  instr_u      instr_i;
  logic        wb_valid_o;
  logic        wb_we_o;
  logic        illegal_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;

  vector_t     vectors [$];
  vector_t     pending [2];
  logic [31:0] ref_regs [32];
  integer      seed;
  logic        load_done;

  tiny_core u_tiny_core (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_we_o       (wb_we_o),
    .illegal_o     (illegal_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////
  // Encoders and table helpers

  function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] funct3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, funct3, rd, OPC_OP_IMM};
  endfunction

  task automatic push_vector(input logic [31:0] instr, input logic we, input logic illegal,
                             input logic [4:0] rd, input logic [31:0] data);
    vector_t v;
    v.valid   = 1'b1;
    v.instr   = instr;
    v.we      = we;
    v.illegal = illegal;
    v.rd      = rd;
    v.data    = data;
    vectors.push_back(v);
  endtask

  task automatic push_bubble();
    vectors.push_back('0);
  endtask

  `include "tb_vectors.svh"

  //////////////////////////////
  // Checking

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // Bubbles must leave all strobes low
  task automatic check_result(input vector_t e);
    check_value("wb_valid_o", 32'(wb_valid_o), 32'(e.valid));
    check_value("wb_we_o", 32'(wb_we_o), 32'(e.we));
    check_value("illegal_o", 32'(illegal_o), 32'(e.illegal));
    // Target index shows for legal and illegal items alike
    if (e.valid) begin
      check_value("wb_rd_o", 32'(wb_rd_o), 32'(e.rd));
    end
    if (e.we) begin
      check_value("wb_data_o", wb_data_o, e.data);
    end
  endtask

  // Drive one slot and check the slot from two edges back
  task automatic issue(input vector_t v);
    @(posedge clk_i);
    #1;
    check_result(pending[1]);
    pending[1] = pending[0];
    pending[0] = v;
    instr_valid_i = v.valid;
    instr_i       = v.instr;
    // Architectural register state in program order
    if (v.valid && v.we) begin
      ref_regs[v.rd] = v.data;
    end
  endtask

  //////////////////////////////
  // Reference model for random ops

  function automatic vector_t random_vector(input logic [31:0] rnd);
    vector_t     v;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    int          op;
    // Only x0..x7 so dependencies come often
    rd  = {2'b00, rnd[2:0]};
    rs1 = {2'b00, rnd[5:3]};
    rs2 = {2'b00, rnd[8:6]};
    imm = rnd[20:9];
    op  = int'(rnd[31:24]) % 11;
    a   = ref_regs[rs1];
    b   = (op < 6) ? ref_regs[rs2] : {{20{imm[11]}}, imm};
    v.valid   = 1'b1;
    v.illegal = 1'b0;
    v.rd      = rd;
    v.we      = (rd != 5'd0);
    case (op)
      0: v.instr = enc_r(F7_BASE, F3_ADD, rd, rs1, rs2);
      1: v.instr = enc_r(F7_SUB, F3_ADD, rd, rs1, rs2);
      2: v.instr = enc_r(F7_BASE, F3_AND, rd, rs1, rs2);
      3: v.instr = enc_r(F7_BASE, F3_OR, rd, rs1, rs2);
      4: v.instr = enc_r(F7_BASE, F3_XOR, rd, rs1, rs2);
      5: v.instr = enc_r(F7_BASE, F3_SLT, rd, rs1, rs2);
      6: v.instr = enc_i(F3_ADD, rd, rs1, imm);
      7: v.instr = enc_i(F3_AND, rd, rs1, imm);
      8: v.instr = enc_i(F3_OR, rd, rs1, imm);
      9: v.instr = enc_i(F3_XOR, rd, rs1, imm);
      default: v.instr = enc_i(F3_SLT, rd, rs1, imm);
    endcase
    case (op)
      0, 6: v.data = a + b;
      1: v.data = a - b;
      2, 7: v.data = a & b;
      3, 8: v.data = a | b;
      4, 9: v.data = a ^ b;
      default: v.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
    return v;
  endfunction

  //////////////////////////////
  // Main sequence

  initial begin : stimulus
    logic [31:0] rnd;
    seed          = 32'ha6db;
    load_done     = 1'b0;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pending[0]    = '0;
    pending[1]    = '0;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = 32'h0;
    end
    load_vectors();
    load_done = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Directed table
    for (int i = 0; i < vectors.size(); i++) begin
      issue(vectors[i]);
    end

    // Random legal ops with about one bubble in eight
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd = $random(seed);
      if (rnd[23:21] == 3'd0) begin
        issue('0);
      end else begin
        issue(random_vector(rnd));
      end
    end

    // Drain the last two slots
    issue('0);
    issue('0);
    $display("TEST OK");
    $finish;
  end

  // Watchdog sized from the number of issued slots
  initial begin : watchdog
    int limit;
    wait (load_done);
    limit = (vectors.size() + NUM_RANDOM + 20) * CLK_PERIOD;
    #(limit);
    $display("Run timed out after %0d time units", limit);
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule

//--- src.f
+incdir+test
src/core_pkg.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/tiny_core.sv
test/tb_tiny_core.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f src.f --top-module tb_tiny_core -o tb_tiny_core \
  && ./obj_dir/tb_tiny_core \
  || exit 1
